/* src/plic_pkg.sv */
// Shared definitions for the eight-source, single-target interrupt controller.
// Holds the sizes, register map, Wishbone request and response structs, the
// configuration bundle passed from the register block to the target, and the
// union used to view a register word as raw bits or as priority nibbles.
// Every RTL and testbench file refers to these through plic_pkg:: names.

package plic_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Number of interrupt sources, IDs run 1 to NUM_SRC
  localparam int NUM_SRC  = 8;
  // Highest priority a source can carry
  localparam int MAX_PRIO = 3;
  // Bits needed to hold 0..MAX_PRIO
  localparam int PRIO_W   = $clog2(MAX_PRIO + 1);
  // Source ID width, wide enough for 0..NUM_SRC
  localparam int SRC_W    = 4;
  // Word address width of the register block
  localparam int ADR_W    = 3;

  ////////////////////////////////////////
  // Register map (word addresses)
  ////////////////////////////////////////

  // Eight 4-bit priority nibbles
  localparam logic [ADR_W-1:0] ADR_PRIO   = 3'd0;
  // Interrupt enable, one bit per source
  localparam logic [ADR_W-1:0] ADR_IE     = 3'd1;
  // Detection mode, 0 level and 1 edge
  localparam logic [ADR_W-1:0] ADR_LE     = 3'd2;
  // Target threshold
  localparam logic [ADR_W-1:0] ADR_THRESH = 3'd3;
  // Pending vector, read only
  localparam logic [ADR_W-1:0] ADR_IP     = 3'd4;
  // Claim on read, complete on write
  localparam logic [ADR_W-1:0] ADR_CC     = 3'd5;
  // Software interrupt bit
  localparam logic [ADR_W-1:0] ADR_MSIP   = 3'd6;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  // Bit n-1 belongs to source n
  typedef logic [NUM_SRC-1:0] src_vec_t;
  // Source ID, 0 means none
  typedef logic [SRC_W-1:0]   src_id_t;
  typedef logic [PRIO_W-1:0]  prio_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [31:0]      dat;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Configuration seen by the target
  typedef struct packed {
    prio_t [NUM_SRC-1:0] prio;   // Entry n-1 is source n
    src_vec_t            ie;
    prio_t               thresh;
  } plic_cfg_t;

  // Register word, raw or as priority nibbles
  // Nibble n-1 is source n, only its low PRIO_W bits are kept
  typedef union packed {
    logic [31:0]              raw;
    logic [NUM_SRC-1:0][3:0]  nib;
  } plic_word_u;

endpackage

/* src/plic_gateway.sv */
// Interrupt gateway for all sources.
// Samples the raw source lines, detects level or edge per source and turns
// them into pending bits. A source stays in service from the moment it is
// taken until software completes it, so it cannot be taken twice.
// Claim and complete arrive as one-cycle one-hot pulses from the register block.

`timescale 1ns/1ps

module plic_gateway (
  input  logic               clk_i,
  input  logic               reset_i,
  // Raw interrupt lines
  input  plic_pkg::src_vec_t src_i,
  // Detection mode, 1 for edge
  input  plic_pkg::src_vec_t le_i,
  // Claim clears pending
  input  plic_pkg::src_vec_t claim_i,
  // Complete clears in service
  input  plic_pkg::src_vec_t complete_i,
  // Pending vector
  output plic_pkg::src_vec_t ip_o
);

  // Previous sample of the lines
  plic_pkg::src_vec_t src_q;
  // Pending bits
  plic_pkg::src_vec_t ip_q;
  // In-service bits
  plic_pkg::src_vec_t ia_q;
  // Rising edge seen this cycle
  plic_pkg::src_vec_t rise;
  // Sources taken this cycle
  plic_pkg::src_vec_t take;

  ////////////////////////////////////////
  // Detection
  ////////////////////////////////////////

  always_comb begin
    rise = src_i & ~src_q;
    // Edge sources need a rise, level sources only a high line
    // Nothing is taken while the source is still in service
    take = ~ia_q & ((le_i & rise) | (~le_i & src_i));
  end

  ////////////////////////////////////////
  // Pending and in-service state
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q <= '0;
      ip_q  <= '0;
      ia_q  <= '0;
    end else begin
      src_q <= src_i;
      // Claim only hits a source that is already pending
      ip_q  <= (ip_q | take) & ~claim_i;
      // After complete a high level source is taken again next cycle
      ia_q  <= (ia_q | take) & ~complete_i;
    end
  end

  // Pending goes straight to the target and the IP register
  assign ip_o = ip_q;

endmodule

/* src/plic_target.sv */
// Target arbitration for the single interrupt target.
// Scans the pending sources and picks the enabled one with the highest
// priority above the threshold, lowest ID on a tie. The interrupt line
// and winning ID are registered, so they follow pending and
// configuration changes by one cycle.

`timescale 1ns/1ps

module plic_target (
  input  logic                clk_i,
  input  logic                reset_i,
  // Pending vector from the gateway
  input  plic_pkg::src_vec_t  ip_i,
  // Priorities, enables and threshold
  input  plic_pkg::plic_cfg_t cfg_i,
  // Interrupt request to the hart
  output logic                irq_o,
  // Winning source, 0 when none
  output plic_pkg::src_id_t   irq_id_o
);

  // Sources both pending and enabled
  plic_pkg::src_vec_t cand;
  // Running best during the scan
  plic_pkg::prio_t    best_prio;
  plic_pkg::src_id_t  best_id;
  // Registered outputs
  logic               irq_q;
  plic_pkg::src_id_t  irq_id_q;

  assign cand = ip_i & cfg_i.ie;

  ////////////////////////////////////////
  // Winner scan
  ////////////////////////////////////////

  // Start at the threshold so only strictly higher priorities win
  // Strict compare keeps the lowest ID among equal priorities
  always_comb begin
    best_prio = cfg_i.thresh;
    best_id   = '0;
    for (int s = 0; s < plic_pkg::NUM_SRC; s++) begin
      if (cand[s] && (cfg_i.prio[s] > best_prio)) begin
        best_prio = cfg_i.prio[s];
        best_id   = plic_pkg::src_id_t'(s + 1);
      end
    end
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_q    <= 1'b0;
      irq_id_q <= '0;
    end else begin
      // A non-zero ID means some source won
      irq_q    <= (best_id != '0);
      irq_id_q <= best_id;
    end
  end

  assign irq_o    = irq_q;
  assign irq_id_o = irq_id_q;

endmodule

/* src/plic_regs.sv */
// Wishbone classic register block of the interrupt controller.
// Holds priority, enable, edge mode, threshold and msip, reads back the
// pending vector, and turns CC reads and writes into one-cycle claim and
// complete pulses for the gateway. Every access is a whole 32-bit word,
// unmapped words read zero and ignore writes.

`timescale 1ns/1ps

module plic_regs (
  input  logic                clk_i,
  input  logic                reset_i,
  // Bus slave port
  input  plic_pkg::wb_req_t   wb_i,
  output plic_pkg::wb_rsp_t   wb_o,
  // Pending vector for IP reads
  input  plic_pkg::src_vec_t  ip_i,
  // Current winner for claim reads
  input  plic_pkg::src_id_t   irq_id_i,
  // Configuration to the target
  output plic_pkg::plic_cfg_t cfg_o,
  // Detection mode to the gateway
  output plic_pkg::src_vec_t  le_o,
  // One-hot pulses to the gateway
  output plic_pkg::src_vec_t  claim_o,
  output plic_pkg::src_vec_t  complete_o,
  // Software interrupt
  output logic                msip_o
);

  // Request seen on the bus
  logic                        req;
  // Request accepted, ack next edge
  logic                        take;
  logic                        ack_q;
  // Set after ack until stb drops
  logic                        done_q;
  // Captured request fields
  logic                        we_q;
  logic [plic_pkg::ADR_W-1:0]  adr_q;
  logic [31:0]                 dat_q;
  // Access strobes in the ack cycle
  logic                        wr_en;
  logic                        rd_en;
  // Register state
  plic_pkg::plic_cfg_t         cfg_q;
  plic_pkg::src_vec_t          le_q;
  logic                        msip_q;
  // Word views for the priority register
  plic_pkg::plic_word_u        wr_word;
  plic_pkg::plic_word_u        rd_word;
  // ID carried by a complete write
  plic_pkg::src_id_t           cc_id;

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  assign req  = wb_i.cyc & wb_i.stb;
  // Only a fresh request is taken, a held one is not acked again
  assign take = req & ~ack_q & ~done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= take;
      done_q <= req & (ack_q | done_q);
    end
  end

  // Payload capture, master holds it stable anyway
  always_ff @(posedge clk_i) begin
    if (take) begin
      we_q  <= wb_i.we;
      adr_q <= wb_i.adr;
      dat_q <= wb_i.dat;
    end
  end

  // Writes land at the edge that ends the ack cycle
  assign wr_en = ack_q & we_q;
  assign rd_en = ack_q & ~we_q;

  ////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////

  always_comb begin
    wr_word.raw = dat_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q  <= '0;
      le_q   <= '0;
      msip_q <= 1'b0;
    end else if (wr_en) begin
      case (adr_q)
        plic_pkg::ADR_PRIO: begin
          // Low bits of each nibble only
          for (int s = 0; s < plic_pkg::NUM_SRC; s++) begin
            cfg_q.prio[s] <= wr_word.nib[s][plic_pkg::PRIO_W-1:0];
          end
        end
        plic_pkg::ADR_IE:     cfg_q.ie     <= dat_q[plic_pkg::NUM_SRC-1:0];
        plic_pkg::ADR_LE:     le_q         <= dat_q[plic_pkg::NUM_SRC-1:0];
        plic_pkg::ADR_THRESH: cfg_q.thresh <= dat_q[plic_pkg::PRIO_W-1:0];
        plic_pkg::ADR_MSIP:   msip_q       <= dat_q[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Unused bits and unmapped words stay zero
  always_comb begin
    rd_word.raw = '0;
    case (adr_q)
      plic_pkg::ADR_PRIO: begin
        for (int s = 0; s < plic_pkg::NUM_SRC; s++) begin
          rd_word.nib[s] = 4'(cfg_q.prio[s]);
        end
      end
      plic_pkg::ADR_IE:     rd_word.raw[plic_pkg::NUM_SRC-1:0] = cfg_q.ie;
      plic_pkg::ADR_LE:     rd_word.raw[plic_pkg::NUM_SRC-1:0] = le_q;
      plic_pkg::ADR_THRESH: rd_word.raw[plic_pkg::PRIO_W-1:0]  = cfg_q.thresh;
      plic_pkg::ADR_IP:     rd_word.raw[plic_pkg::NUM_SRC-1:0] = ip_i;
      // Claim returns the winner seen in the ack cycle
      plic_pkg::ADR_CC:     rd_word.raw[plic_pkg::SRC_W-1:0]   = irq_id_i;
      plic_pkg::ADR_MSIP:   rd_word.raw[0]                     = msip_q;
      default: ;
    endcase
  end

  always_comb begin
    wb_o.ack = ack_q;
    wb_o.dat = rd_en ? rd_word.raw : '0;
  end

  ////////////////////////////////////////
  // Claim and complete pulses
  ////////////////////////////////////////

  assign cc_id = dat_q[plic_pkg::SRC_W-1:0];

  // ID 0 and out-of-range IDs match no source
  always_comb begin
    for (int s = 0; s < plic_pkg::NUM_SRC; s++) begin
      claim_o[s]    = rd_en && (adr_q == plic_pkg::ADR_CC) &&
                      (irq_id_i == plic_pkg::src_id_t'(s + 1));
      complete_o[s] = wr_en && (adr_q == plic_pkg::ADR_CC) &&
                      (cc_id == plic_pkg::src_id_t'(s + 1));
    end
  end

  assign cfg_o  = cfg_q;
  assign le_o   = le_q;
  assign msip_o = msip_q;

endmodule

/* src/plic_top.sv */
// Top level of the interrupt controller.
// Connects the gateway, the Wishbone register block and the target.
// Gateway and register block run side by side, one producing pending bits
// and the other configuration, and the target combines both.

`timescale 1ns/1ps

module plic_top (
  input  logic              clk_i,
  input  logic              reset_i,
  // Wishbone classic slave
  input  plic_pkg::wb_req_t wb_i,
  output plic_pkg::wb_rsp_t wb_o,
  // Raw interrupt sources
  input  plic_pkg::src_vec_t intr_src_i,
  // Target notification
  output logic              irq_o,
  output plic_pkg::src_id_t irq_id_o,
  // Software interrupt
  output logic              msip_o
);

  // Gateway to target and registers
  plic_pkg::src_vec_t  ip;
  // Registers to gateway
  plic_pkg::src_vec_t  le;
  plic_pkg::src_vec_t  claim;
  plic_pkg::src_vec_t  complete;
  // Registers to target
  plic_pkg::plic_cfg_t cfg;

  ////////////////////////////////////////
  // Gateway
  ////////////////////////////////////////

  plic_gateway u_gateway (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .src_i      (intr_src_i),
    .le_i       (le),
    .claim_i    (claim),
    .complete_i (complete),
    .ip_o       (ip)
  );

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  // Winner ID feeds back for claim reads
  plic_regs u_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_i       (wb_i),
    .wb_o       (wb_o),
    .ip_i       (ip),
    .irq_id_i   (irq_id_o),
    .cfg_o      (cfg),
    .le_o       (le),
    .claim_o    (claim),
    .complete_o (complete),
    .msip_o     (msip_o)
  );

  ////////////////////////////////////////
  // Target
  ////////////////////////////////////////

  plic_target u_target (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ip_i       (ip),
    .cfg_i      (cfg),
    .irq_o      (irq_o),
    .irq_id_o   (irq_id_o)
  );

endmodule

/* sim/plic_asserts.sv */
// Concurrent checks on the Wishbone handshake and the interrupt outputs.
// Bound into the controller top level from the testbench, so every port
// here only observes top-level signals.

`timescale 1ns/1ps

module plic_asserts (
  input logic               clk_i,
  input logic               reset_i,
  input plic_pkg::wb_req_t  wb_req_i,
  input plic_pkg::wb_rsp_t  wb_rsp_i,
  input logic               irq_i,
  input plic_pkg::src_id_t  irq_id_i
);

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Mid-cycle sample, master drops stb on the falling edge after ack
  ack_in_request: assert property (@(negedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("ack outside a cyc and stb request");

  // Single-cycle ack
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack held for two cycles");

  ////////////////////////////////////////
  // Interrupt outputs
  ////////////////////////////////////////

  irq_has_id: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_i |-> (irq_id_i != '0))
    else $error("irq raised with source ID 0");

  // Line cleared by reset
  irq_low_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !irq_i)
    else $error("irq high in the cycle after reset");

endmodule

/* sim/plic_tb.sv */
// Testbench for the interrupt controller top level.
// Replays the command lines of sim/plic_stim.txt as Wishbone cycles,
// source drives and output checks, with 0 to 3 random idle cycles between
// commands. Run from the project root so the stim path resolves.

`timescale 1ns/1ps

module plic_tb;

  localparam string STIM_PATH = "sim/plic_stim.txt";

  logic                clk;
  logic                reset;
  plic_pkg::wb_req_t   wb_req;
  plic_pkg::wb_rsp_t   wb_rsp;
  plic_pkg::src_vec_t  src;
  logic                irq;
  plic_pkg::src_id_t   irq_id;
  logic                msip;

  // Command lines, comments and blanks dropped
  string               lines[$];
  int                  cycle_cnt = 0;
  // Zero until the stim file is loaded
  int                  cycle_limit = 0;

  plic_top plic_top_inst (
    .clk_i      (clk),
    .reset_i    (reset),
    .wb_i       (wb_req),
    .wb_o       (wb_rsp),
    .intr_src_i (src),
    .irq_o      (irq),
    .irq_id_o   (irq_id),
    .msip_o     (msip)
  );

  bind plic_top plic_asserts plic_asserts_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_req_i (wb_i),
    .wb_rsp_i (wb_o),
    .irq_i    (irq_o),
    .irq_id_i (irq_id_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Failure and compare helpers
  ////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_word(string name, plic_pkg::plic_word_u exp,
                            plic_pkg::plic_word_u act);
    if (act.raw !== exp.raw)
      abort_run($sformatf("[ERROR] %0t %s expected %08h actual %08h",
                          $time, name, exp.raw, act.raw));
  endtask

  task automatic check_id(string name, plic_pkg::src_id_t exp, plic_pkg::src_id_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act));
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      abort_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
  end

  ////////////////////////////////////////
  // Bus and source drivers
  ////////////////////////////////////////

  // One Wishbone classic cycle, request held until ack
  task automatic bus_access(input logic we, input logic [plic_pkg::ADR_W-1:0] adr,
                            input logic [31:0] dat, output plic_pkg::plic_word_u rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < 4);
    if (!wb_rsp.ack)
      abort_run($sformatf("No ack from the bus slave within 4 cycles at %0t", $time));
    rdata.raw = wb_rsp.dat;
    wb_req = '0;
  endtask

  // Waits for irq with the given ID, 2 cycles nominal
  task automatic wait_irq(plic_pkg::src_id_t exp_id);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!(irq === 1'b1 && irq_id === exp_id) && waited < 4);
    check_bit("irq_o", 1'b1, irq);
    check_id("irq_id_o", exp_id, irq_id);
  endtask

  task automatic load_stim();
    int    fd;
    string line;
    fd = $fopen(STIM_PATH, "r");
    if (fd == 0)
      abort_run($sformatf("Cannot open stimulus file %s", STIM_PATH));
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
        lines.push_back(line);
    end
    $fclose(fd);
  endtask

  // One stim line, fields are command letter and up to two hex words
  task automatic run_command(string line);
    logic [7:0]           cmd;
    logic [31:0]          a;
    logic [31:0]          b;
    int                   nf;
    plic_pkg::plic_word_u rdata;
    plic_pkg::plic_word_u exp_word;
    a  = '0;
    b  = '0;
    nf = $sscanf(line, "%c %h %h", cmd, a, b);
    case (cmd)
      "W": bus_access(1'b1, a[plic_pkg::ADR_W-1:0], b, rdata);
      "R": begin
        bus_access(1'b0, a[plic_pkg::ADR_W-1:0], 32'h0, rdata);
        exp_word.raw = b;
        check_word($sformatf("wb_o.dat@%0d", a), exp_word, rdata);
      end
      "S": begin
        @(negedge clk);
        src = a[plic_pkg::NUM_SRC-1:0];
      end
      // Lines high for exactly one cycle
      "P": begin
        @(negedge clk);
        src = src | a[plic_pkg::NUM_SRC-1:0];
        @(negedge clk);
        src = src & ~a[plic_pkg::NUM_SRC-1:0];
      end
      "I": wait_irq(a[plic_pkg::SRC_W-1:0]);
      "N": begin
        repeat (4) @(negedge clk);
        check_bit("irq_o", 1'b0, irq);
        check_id("irq_id_o", '0, irq_id);
      end
      "M": begin
        @(negedge clk);
        check_bit("msip_o", a[0], msip);
      end
      default: abort_run($sformatf("Unknown stim command in line: %s (%0d fields)", line, nf));
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(36084));
    reset  = 1'b1;
    wb_req = '0;
    src    = '0;
    load_stim();
    cycle_limit = 40 * lines.size() + 20;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (lines[i]) begin
      run_command(lines[i]);
      repeat ($urandom % 4) @(negedge clk);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* sim/plic_stim.txt */
# cmd a b in hex: W adr data | R adr expect | S src vector | P src one-cycle pulse
# I id = irq_o with that ID within 4 cycles | N = irq_o low after 4 | M bit = msip_o
R 0 00000000
W 0 FFFFFFFF
R 0 33333333
W 1 FFFFFFFF
R 1 000000FF
W 2 FFFFFFFF
R 2 000000FF
W 3 FFFFFFFF
R 3 00000003
W 6 FFFFFFFF
M 1
R 6 00000001
W 6 00000000
M 0
R 7 00000000
W 2 00000000
W 3 00000000
W 0 00213321
W 1 0000000F
S 03
I 2
S 0F
I 3
R 4 0000000F
R 5 00000003
I 4
R 5 00000004
I 2
R 5 00000002
I 1
R 5 00000001
N
R 4 00000000
W 5 00000003
I 3
S 00
R 5 00000003
N
W 5 00000001
W 5 00000002
W 5 00000003
W 5 00000004
N
R 4 00000000
W 3 00000001
W 1 0000005F
S 70
N
R 4 00000070
W 0 00223321
I 5
W 0 03223321
I 7
S 00
R 5 00000007
I 5
R 5 00000005
N
W 5 00000007
W 5 00000005
W 2 00000080
W 0 30000000
W 1 00000080
W 3 00000000
P 80
R 4 000000A0
I 8
R 5 00000008
N
P 80
N
R 4 00000020
W 5 00000008
N
R 4 00000020

/* files.f */
src/plic_pkg.sv
src/plic_gateway.sv
src/plic_target.sv
src/plic_regs.sv
src/plic_top.sv
sim/plic_asserts.sv
sim/plic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the interrupt controller testbench with Verilator and runs it.
# Exits non-zero unless the pass message shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module plic_tb --Mdir "$OBJ_DIR" -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$("./$OBJ_DIR/Vplic_tb" 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
